// File: cpuPkg.sv
package cpuPkg;

	localparam int wordSize = 16;
	localparam int numRegs = 4;

	localparam logic [3:0] opBne = 4'd0;
	localparam logic [3:0] opBeq = 4'd1;
	localparam logic [3:0] opBgz = 4'd2;
	localparam logic [3:0] opBlz = 4'd3;
	localparam logic [3:0] opAdi = 4'd4;
	localparam logic [3:0] opOri = 4'd5;
	localparam logic [3:0] opLhi = 4'd6;
	localparam logic [3:0] opLwd = 4'd7;
	localparam logic [3:0] opSwd = 4'd8;
	localparam logic [3:0] opJmp = 4'd9;
	localparam logic [3:0] opJal = 4'd10;
	localparam logic [3:0] opRtype = 4'd15;

	localparam logic [5:0] fnAdd = 6'd0;
	localparam logic [5:0] fnSub = 6'd1;
	localparam logic [5:0] fnAnd = 6'd2;
	localparam logic [5:0] fnOrr = 6'd3;
	localparam logic [5:0] fnNot = 6'd4;
	localparam logic [5:0] fnTcp = 6'd5;
	localparam logic [5:0] fnShl = 6'd6;
	localparam logic [5:0] fnShr = 6'd7;
	localparam logic [5:0] fnJpr = 6'd25;
	localparam logic [5:0] fnJrl = 6'd26;

	localparam logic [3:0] aluAdd = 4'd0;
	localparam logic [3:0] aluSub = 4'd1;
	localparam logic [3:0] aluAnd = 4'd2;
	localparam logic [3:0] aluOr = 4'd3;
	localparam logic [3:0] aluNot = 4'd4;
	localparam logic [3:0] aluTcp = 4'd5;
	localparam logic [3:0] aluShl = 4'd6;
	localparam logic [3:0] aluShr = 4'd7;
	localparam logic [3:0] aluZero = 4'd8;

	// Sequencer phases.
	localparam logic [1:0] stFetch = 2'd0;
	localparam logic [1:0] stExec = 2'd1;
	localparam logic [1:0] stMem = 2'd2;

	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [1:0] rd;
			logic [5:0] func;
		} rFmt;
		struct packed {
			logic [3:0] opcode;
			logic [1:0] rs;
			logic [1:0] rt;
			logic [7:0] imm;
		} iFmt;
		struct packed {
			logic [3:0] opcode;
			logic [11:0] target;
		} jFmt;
	} instrWord;

endpackage

// File: ctrlIf.sv
`timescale 1ns/100ps

interface ctrlIf;
	cpuPkg::instrWord instr;
	logic jump;
	logic jumpReg; // JPR and JRL.
	logic branch;
	logic link;
	logic memToReg;
	logic memRead;
	logic memWrite;
	logic regDst;
	logic regWrite;
	logic aluSrc;
	logic [3:0] aluOp;

	modport decoder (
		input instr,
		output jump, jumpReg, branch, link, memToReg, memRead, memWrite,
		output regDst, regWrite, aluSrc, aluOp
	);

	modport path (
		output instr,
		input jump, jumpReg, branch, link, memToReg, memRead, memWrite,
		input regDst, regWrite, aluSrc, aluOp
	);
endinterface

// File: controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
	ctrlIf.decoder ctrl
);

	always_comb begin
		ctrl.jump = 1'b0;
		ctrl.jumpReg = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.link = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.regDst = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.aluSrc = 1'b0;
		ctrl.aluOp = cpuPkg::aluZero;

		case (ctrl.instr.rFmt.opcode)
			cpuPkg::opRtype: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
				case (ctrl.instr.rFmt.func)
					cpuPkg::fnAdd: ctrl.aluOp = cpuPkg::aluAdd;
					cpuPkg::fnSub: ctrl.aluOp = cpuPkg::aluSub;
					cpuPkg::fnAnd: ctrl.aluOp = cpuPkg::aluAnd;
					cpuPkg::fnOrr: ctrl.aluOp = cpuPkg::aluOr;
					cpuPkg::fnNot: ctrl.aluOp = cpuPkg::aluNot;
					cpuPkg::fnTcp: ctrl.aluOp = cpuPkg::aluTcp;
					cpuPkg::fnShl: ctrl.aluOp = cpuPkg::aluShl;
					cpuPkg::fnShr: ctrl.aluOp = cpuPkg::aluShr;
					cpuPkg::fnJpr: begin
						ctrl.jump = 1'b1;
						ctrl.jumpReg = 1'b1;
						ctrl.regDst = 1'b0;
						ctrl.regWrite = 1'b0;
					end
					cpuPkg::fnJrl: begin
						ctrl.jump = 1'b1;
						ctrl.jumpReg = 1'b1;
						ctrl.link = 1'b1; // Links into rd.
					end
					default: begin
						ctrl.regDst = 1'b0;
						ctrl.regWrite = 1'b0;
					end
				endcase
			end
			cpuPkg::opAdi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = cpuPkg::aluAdd;
			end
			cpuPkg::opOri: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = cpuPkg::aluOr;
			end
			cpuPkg::opLhi: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1; // Upper immediate without memRead.
			end
			cpuPkg::opLwd: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = cpuPkg::aluAdd;
			end
			cpuPkg::opSwd: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = cpuPkg::aluAdd;
			end
			cpuPkg::opBne, cpuPkg::opBeq, cpuPkg::opBgz, cpuPkg::opBlz: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = cpuPkg::aluSub; // Compare rs with rt.
			end
			cpuPkg::opJmp: ctrl.jump = 1'b1;
			cpuPkg::opJal: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			default: ; // Unknown encodings are no-ops.
		endcase
	end

endmodule

// File: alu.sv
`timescale 1ns/100ps

module alu (
	input logic [15:0] a,
	input logic [15:0] b,
	input logic [3:0] op,
	output logic [15:0] result,
	output logic zero,
	output logic negative
);

	always_comb begin
		case (op)
			cpuPkg::aluAdd: result = a + b;
			cpuPkg::aluSub: result = a - b;
			cpuPkg::aluAnd: result = a & b;
			cpuPkg::aluOr: result = a | b;
			cpuPkg::aluNot: result = ~a;
			cpuPkg::aluTcp: result = ~a + 16'd1;
			cpuPkg::aluShl: result = a << 1;
			cpuPkg::aluShr: result = $signed(a) >>> 1; // Keeps the sign bit.
			default: result = '0;
		endcase
	end

	// Flags of rs for BGZ and BLZ.
	assign zero = (a == '0);
	assign negative = a[cpuPkg::wordSize-1];

endmodule

// File: registerFile.sv
`timescale 1ns/100ps

module registerFile (
	input logic clk,
	input logic rstN,
	input logic [1:0] readAddr1,
	input logic [1:0] readAddr2,
	input logic [1:0] writeAddr,
	input logic [15:0] writeData,
	input logic writeEn,
	output logic [15:0] readData1,
	output logic [15:0] readData2
);

	logic [cpuPkg::wordSize-1:0] regs [cpuPkg::numRegs];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < cpuPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];

endmodule

// File: datapath.sv
`timescale 1ns/100ps

module datapath (
	input logic clk,
	input logic rstN,
	ctrlIf.path ctrl,
	output logic readM,
	output logic writeM,
	output logic [15:0] address,
	inout wire [15:0] data,
	input logic inputReady,
	input logic ackOutput
);

	logic [1:0] state;
	logic [cpuPkg::wordSize-1:0] pc;
	logic [cpuPkg::wordSize-1:0] pcPlusOne;
	logic [cpuPkg::wordSize-1:0] nextPc;
	cpuPkg::instrWord ir;
	logic [cpuPkg::wordSize-1:0] rsData;
	logic [cpuPkg::wordSize-1:0] rtData;
	logic [cpuPkg::wordSize-1:0] immExt;
	logic [cpuPkg::wordSize-1:0] aluB;
	logic [cpuPkg::wordSize-1:0] aluResult;
	logic [cpuPkg::wordSize-1:0] writeData;
	logic [1:0] writeAddr;
	logic rsZero;
	logic rsNegative;
	logic branchTaken;
	logic regWriteEn;
	logic loadDone;
	logic storeDone;

	assign ctrl.instr = ir;
	assign pcPlusOne = pc + 16'd1;
	assign loadDone = (state == cpuPkg::stMem) && readM && inputReady;
	assign storeDone = (state == cpuPkg::stMem) && writeM && ackOutput;

	// ORI zero-extends, all others sign-extend.
	assign immExt = (ir.iFmt.opcode == cpuPkg::opOri) ? {8'h00, ir.iFmt.imm}
		: {{8{ir.iFmt.imm[7]}}, ir.iFmt.imm};
	assign aluB = ctrl.aluSrc ? immExt : rtData;

	registerFile uRegs (
		.clk(clk),
		.rstN(rstN),
		.readAddr1(ir.rFmt.rs),
		.readAddr2(ir.rFmt.rt),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeEn(regWriteEn),
		.readData1(rsData),
		.readData2(rtData)
	);

	alu uAlu (
		.a(rsData),
		.b(aluB),
		.op(ctrl.aluOp),
		.result(aluResult),
		.zero(rsZero),
		.negative(rsNegative)
	);

	// Low opcode bits pick the branch condition.
	always_comb begin
		branchTaken = 1'b0;
		if (ctrl.branch) begin
			case (ir.iFmt.opcode[1:0])
				cpuPkg::opBne[1:0]: branchTaken = (aluResult != '0);
				cpuPkg::opBeq[1:0]: branchTaken = (aluResult == '0);
				cpuPkg::opBgz[1:0]: branchTaken = !rsNegative && !rsZero;
				default: branchTaken = rsNegative; // BLZ.
			endcase
		end
	end

	always_comb begin
		if (ctrl.jumpReg) begin
			nextPc = rsData;
		end else if (ctrl.jump) begin
			nextPc = {pc[15:12], ir.jFmt.target};
		end else if (branchTaken) begin
			nextPc = pcPlusOne + immExt;
		end else begin
			nextPc = pcPlusOne;
		end
	end

	// JAL always links into register 2.
	assign writeAddr = ctrl.link ? (ctrl.jumpReg ? ir.rFmt.rd : 2'd2)
		: (ctrl.regDst ? ir.rFmt.rd : ir.rFmt.rt);

	always_comb begin
		if (ctrl.memRead) begin
			writeData = data; // Taken straight off the bus.
		end else if (ctrl.link) begin
			writeData = pcPlusOne;
		end else if (ctrl.memToReg) begin
			writeData = {ir.iFmt.imm, 8'h00};
		end else begin
			writeData = aluResult;
		end
	end

	assign regWriteEn = ctrl.regWrite
		&& (ctrl.memRead ? loadDone : (state == cpuPkg::stExec));

	assign address = (state == cpuPkg::stMem) ? aluResult : pc;
	assign data = writeM ? rtData : 16'bz;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= cpuPkg::stFetch;
			pc <= '0;
			readM <= 1'b0;
			writeM <= 1'b0;
		end else begin
			case (state)
				cpuPkg::stFetch: begin
					if (readM && inputReady) begin
						ir <= data;
						readM <= 1'b0;
						state <= cpuPkg::stExec;
					end else begin
						readM <= 1'b1;
					end
				end
				cpuPkg::stExec: begin
					if (ctrl.memRead) begin
						readM <= 1'b1;
						state <= cpuPkg::stMem;
					end else if (ctrl.memWrite) begin
						writeM <= 1'b1;
						state <= cpuPkg::stMem;
					end else begin
						pc <= nextPc;
						readM <= 1'b1; // Next fetch starts at once.
						state <= cpuPkg::stFetch;
					end
				end
				cpuPkg::stMem: begin
					if (loadDone) begin
						pc <= nextPc;
						readM <= 1'b0; // Drop before the next request.
						state <= cpuPkg::stFetch;
					end else if (storeDone) begin
						pc <= nextPc;
						writeM <= 1'b0;
						readM <= 1'b1;
						state <= cpuPkg::stFetch;
					end
				end
				default: state <= cpuPkg::stFetch;
			endcase
		end
	end

endmodule

// File: cpu.sv
`timescale 1ns/100ps

module cpu (
	input logic clk,
	input logic rstN,
	output logic readM,
	output logic writeM,
	output logic [15:0] address,
	inout wire [15:0] data,
	input logic inputReady,
	input logic ackOutput
);

	ctrlIf ctrlBus ();

	// Combinational decode of the instruction register.
	controlUnit uDecoder (
		.ctrl(ctrlBus.decoder)
	);

	datapath uPath (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrlBus.path),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.data(data),
		.inputReady(inputReady),
		.ackOutput(ackOutput)
	);

endmodule

// File: cpuTb_sva.sv
`timescale 1ns/100ps

module cpuTbSva (
	input logic clk,
	input logic rstN,
	input logic readM,
	input logic writeM,
	input logic [15:0] address,
	input wire [15:0] data,
	input logic inputReady,
	input logic ackOutput
);

	// Bus is quiet on the cycle after a reset edge.
	idleAfterReset: assert property (@(posedge clk) !rstN |=> !readM && !writeM)
		else $error("Bus request active after reset");

	noReadWrite: assert property (@(posedge clk) disable iff (!rstN) !(readM && writeM))
		else $error("readM and writeM high together");

	readHeld: assert property (@(posedge clk) disable iff (!rstN)
		readM && !inputReady |=> readM && $stable(address))
		else $error("Read request changed before inputReady");

	writeHeld: assert property (@(posedge clk) disable iff (!rstN)
		writeM && !ackOutput |=> writeM && $stable(address) && $stable(data))
		else $error("Write request changed before ackOutput");

	firstFetch: assert property (@(posedge clk) $rose(rstN) |=> readM && address == 16'h0000)
		else $error("First fetch after reset not at address zero");

endmodule

bind cpu cpuTbSva sva (.*);

// File: cpuTb.sv
`timescale 1ns/100ps

module cpuTb;

	localparam int progLen = 56;
	localparam logic [15:0] haltAddr = 16'd55;

	logic clk;
	logic rstN;
	logic inputReady;
	logic ackOutput;
	logic readM;
	logic writeM;
	logic [15:0] address;
	wire [15:0] data;
	logic [15:0] busOut;
	logic busDrive;
	logic done;
	logic [15:0] mem [256];
	logic [15:0] expAddr [$];
	logic [15:0] expData [$];

	assign data = busDrive ? busOut : 16'bz;

	cpu dut (
		.clk(clk),
		.rstN(rstN),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.data(data),
		.inputReady(inputReady),
		.ackOutput(ackOutput)
	);

	function automatic logic [15:0] rInstr(input logic [5:0] fn, input logic [1:0] rs,
		input logic [1:0] rt, input logic [1:0] rd);
		return {cpuPkg::opRtype, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] iInstr(input logic [3:0] op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] jInstr(input logic [3:0] op, input logic [11:0] target);
		return {op, target};
	endfunction

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic expectStore(input logic [15:0] addr, input logic [15:0] value);
		expAddr.push_back(addr);
		expData.push_back(value);
	endtask

	task automatic checkStore(input logic [15:0] addr, input logic [15:0] value);
		logic [15:0] a;
		logic [15:0] d;
		assert (expAddr.size() != 0) else reportFailure("Store seen after all expected stores");
		a = expAddr.pop_front();
		d = expData.pop_front();
		assert (addr == a)
			else reportFailure($sformatf("Mismatch address: expected %h, got %h", a, addr));
		assert (value == d)
			else reportFailure($sformatf("Mismatch data: expected %h, got %h", d, value));
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = 16'hC000 ^ i[15:0]; // Unknown opcode, a no-op.
		end
		mem[0] = iInstr(cpuPkg::opLwd, 2'd0, 2'd1, 8'h70);
		mem[1] = iInstr(cpuPkg::opLwd, 2'd0, 2'd2, 8'h71);
		mem[2] = rInstr(cpuPkg::fnAdd, 2'd1, 2'd2, 2'd3);
		mem[3] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h40);
		mem[4] = rInstr(cpuPkg::fnSub, 2'd1, 2'd2, 2'd3);
		mem[5] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h41);
		mem[6] = rInstr(cpuPkg::fnAnd, 2'd1, 2'd2, 2'd3);
		mem[7] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h42);
		mem[8] = rInstr(cpuPkg::fnOrr, 2'd1, 2'd2, 2'd3);
		mem[9] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h43);
		mem[10] = rInstr(cpuPkg::fnNot, 2'd1, 2'd0, 2'd3);
		mem[11] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h44);
		mem[12] = rInstr(cpuPkg::fnTcp, 2'd1, 2'd0, 2'd3);
		mem[13] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h45);
		mem[14] = rInstr(cpuPkg::fnShl, 2'd2, 2'd0, 2'd3);
		mem[15] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h46);
		mem[16] = rInstr(cpuPkg::fnShr, 2'd2, 2'd0, 2'd3);
		mem[17] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h47);
		mem[18] = iInstr(cpuPkg::opAdi, 2'd1, 2'd3, 8'hF0);
		mem[19] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h48);
		mem[20] = iInstr(cpuPkg::opOri, 2'd1, 2'd3, 8'hF0);
		mem[21] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h49);
		mem[22] = iInstr(cpuPkg::opLhi, 2'd0, 2'd3, 8'hA5);
		mem[23] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h4A);
		mem[24] = iInstr(cpuPkg::opLwd, 2'd0, 2'd3, 8'h72);
		mem[25] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h4B);
		mem[26] = iInstr(cpuPkg::opLhi, 2'd0, 2'd3, 8'h00);
		mem[27] = iInstr(cpuPkg::opBne, 2'd1, 2'd2, 8'h01); // Taken.
		mem[28] = iInstr(cpuPkg::opAdi, 2'd3, 2'd3, 8'h01);
		mem[29] = iInstr(cpuPkg::opBeq, 2'd1, 2'd2, 8'h01); // Not taken.
		mem[30] = iInstr(cpuPkg::opAdi, 2'd3, 2'd3, 8'h02);
		mem[31] = iInstr(cpuPkg::opBgz, 2'd1, 2'd0, 8'h01); // Taken.
		mem[32] = iInstr(cpuPkg::opAdi, 2'd3, 2'd3, 8'h04);
		mem[33] = iInstr(cpuPkg::opBlz, 2'd1, 2'd0, 8'h01); // Not taken.
		mem[34] = iInstr(cpuPkg::opAdi, 2'd3, 2'd3, 8'h08);
		mem[35] = iInstr(cpuPkg::opBlz, 2'd2, 2'd0, 8'h01); // Taken.
		mem[36] = iInstr(cpuPkg::opAdi, 2'd3, 2'd3, 8'h10);
		mem[37] = iInstr(cpuPkg::opBeq, 2'd0, 2'd0, 8'h01); // Taken.
		mem[38] = iInstr(cpuPkg::opAdi, 2'd3, 2'd3, 8'h20);
		mem[39] = iInstr(cpuPkg::opBgz, 2'd0, 2'd0, 8'h01); // Zero, not taken.
		mem[40] = iInstr(cpuPkg::opAdi, 2'd3, 2'd3, 8'h40);
		mem[41] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h4C);
		mem[42] = jInstr(cpuPkg::opJmp, 12'd44);
		mem[43] = iInstr(cpuPkg::opAdi, 2'd3, 2'd3, 8'h80); // Skipped by the jump.
		mem[44] = jInstr(cpuPkg::opJal, 12'd47);
		mem[45] = iInstr(cpuPkg::opSwd, 2'd0, 2'd2, 8'h4D);
		mem[46] = jInstr(cpuPkg::opJmp, 12'd50);
		mem[47] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h4E);
		mem[48] = rInstr(cpuPkg::fnJpr, 2'd2, 2'd0, 2'd0);
		mem[50] = iInstr(cpuPkg::opOri, 2'd0, 2'd1, 8'h36);
		mem[51] = rInstr(cpuPkg::fnJrl, 2'd1, 2'd0, 2'd3);
		mem[52] = iInstr(cpuPkg::opAdi, 2'd3, 2'd3, 8'h80); // Skipped by the jump.
		mem[54] = iInstr(cpuPkg::opSwd, 2'd0, 2'd3, 8'h4F);
		mem[55] = jInstr(cpuPkg::opJmp, 12'd55);
		mem[8'h70] = 16'h1234;
		mem[8'h71] = 16'h8F0F;
		mem[8'h72] = 16'h5A5A;
	end

	initial begin
		expectStore(16'h0040, 16'hA143); // 1234 + 8F0F.
		expectStore(16'h0041, 16'h8325);
		expectStore(16'h0042, 16'h0204);
		expectStore(16'h0043, 16'h9F3F);
		expectStore(16'h0044, 16'hEDCB);
		expectStore(16'h0045, 16'hEDCC);
		expectStore(16'h0046, 16'h1E1E);
		expectStore(16'h0047, 16'hC787); // Sign bit kept.
		expectStore(16'h0048, 16'h1224);
		expectStore(16'h0049, 16'h12F4);
		expectStore(16'h004A, 16'hA500);
		expectStore(16'h004B, 16'h5A5A);
		expectStore(16'h004C, 16'h004A); // Only untaken paths add.
		expectStore(16'h004E, 16'h004A);
		expectStore(16'h004D, 16'h002D); // JAL return address.
		expectStore(16'h004F, 16'h0034); // JRL return address.
	end

	// Memory model with random latency.
	initial begin
		int latency;
		void'($urandom(21));
		rstN = 1'b0;
		inputReady = 1'b0;
		ackOutput = 1'b0;
		busOut = '0;
		busDrive = 1'b0;
		done = 1'b0;
		repeat (4) @(posedge clk);
		#1 rstN = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			if (readM || writeM) begin
				latency = $urandom_range(3, 0);
				repeat (latency) begin
					@(posedge clk);
					#1;
				end
				if (readM) begin
					busOut = mem[address[7:0]];
					busDrive = 1'b1;
					inputReady = 1'b1;
					if (address == haltAddr) begin
						done = 1'b1;
					end
				end else begin
					checkStore(address, data);
					mem[address[7:0]] = data;
					ackOutput = 1'b1;
				end
				@(posedge clk);
				#1;
				inputReady = 1'b0;
				ackOutput = 1'b0;
				busDrive = 1'b0;
			end
		end
	end

	initial begin
		repeat (200 * progLen) @(posedge clk);
		reportFailure("Timeout: program never reached its final self-jump");
	end

	initial begin
		wait (done);
		if (expAddr.size() == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			reportFailure("Final self-jump reached with stores still outstanding");
		end
	end

endmodule

// File: sources.f
cpuPkg.sv
ctrlIf.sv
controlUnit.sv
alu.sv
registerFile.sv
datapath.sv
cpu.sv
cpuTb_sva.sv
cpuTb.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - cpuPkg.sv
  - ctrlIf.sv
  - controlUnit.sv
  - alu.sv
  - registerFile.sv
  - datapath.sv
  - cpu.sv
  - target: simulation
    files:
      - cpuTb_sva.sv
      - cpuTb.sv
